//--- Bender.yml
package:
  name: fftCalculator

sources:
  - files:
      - src/fftPkg.sv
      - src/inputButterfly.sv
      - src/quarterButterfly.sv
      - src/finalButterfly.sv
      - src/floatNormalizer.sv
      - src/fftCalculator.sv
  - target: test
    files:
      - verification/fftCalculator_assertions.sv
      - verification/tbFftCalculator.sv

//--- fftCalculator.f
src/fftPkg.sv
src/inputButterfly.sv
src/quarterButterfly.sv
src/finalButterfly.sv
src/floatNormalizer.sv
src/fftCalculator.sv
verification/fftCalculator_assertions.sv
verification/tbFftCalculator.sv

//--- src/fftCalculator.sv
`timescale 1ns/1ps

module fftCalculator (
	input  logic                    Clock,
	input  logic                    rstN,
	input  fftPkg::sampleVec_t      samples,
	output wire fftPkg::resultVec_t results
);

	fftPkg::stage1Vec_t stage1Vec;
	fftPkg::stage2Vec_t stage2Vec;
	fftPkg::fixedVec_t fixedBins;

	//////////////////////////////////////////////////////////////////////
	// Butterfly stages
	//////////////////////////////////////////////////////////////////////

	inputButterfly stage1 (
		.Clock(Clock),
		.rstN(rstN),
		.samples(samples),
		.stage1Out(stage1Vec)
	);

	quarterButterfly stage2 (
		.Clock(Clock),
		.rstN(rstN),
		.stage1In(stage1Vec),
		.stage2Out(stage2Vec)
	);

	finalButterfly stage3 (
		.Clock(Clock),
		.rstN(rstN),
		.stage2In(stage2Vec),
		.fixedOut(fixedBins)
	);

	//////////////////////////////////////////////////////////////////////
	// Normalization with one unit per real and imaginary part
	//////////////////////////////////////////////////////////////////////

	for (genvar bin = 0; bin < 8; bin++) begin : genNorm
		floatNormalizer normReal (
			.Clock(Clock),
			.rstN(rstN),
			.value(fixedBins[bin].realPart),
			.word(results[bin].realPart)
		);

		floatNormalizer normImag (
			.Clock(Clock),
			.rstN(rstN),
			.value(fixedBins[bin].imagPart),
			.word(results[bin].imagPart)
		);
	end

endmodule

//--- src/fftPkg.sv
package fftPkg;

	//////////////////////////////////////////////////////////////////////
	// Data path widths
	//////////////////////////////////////////////////////////////////////

	localparam int sampleWidth = 8;
	localparam int stage1Width = 9;
	localparam int stage2Width = 10;
	localparam int fixedWidth  = 20;

	// Stage 3 values carry 8 fraction bits
	localparam int fracBits = 8;

	// Output word split
	localparam int mantWidth = 15;
	localparam int expWidth  = 5;

	// sqrt(2)/2 scaled by 256
	localparam logic signed [fixedWidth-1:0] twiddleCoef = 181;

	//////////////////////////////////////////////////////////////////////
	// Stage types
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [sampleWidth-1:0] sample_t;
	typedef sample_t [7:0] sampleVec_t;

	typedef logic signed [stage1Width-1:0] stage1_t;
	typedef stage1_t [7:0] stage1Vec_t;

	typedef logic signed [stage2Width-1:0] stage2Part_t;
	typedef struct packed {
		stage2Part_t realPart;
		stage2Part_t imagPart;
	} complex10_t;
	typedef complex10_t [7:0] stage2Vec_t;

	typedef logic signed [fixedWidth-1:0] fixed_t;
	typedef struct packed {
		fixed_t realPart;
		fixed_t imagPart;
	} complexFixed_t;
	typedef complexFixed_t [7:0] fixedVec_t;

	//////////////////////////////////////////////////////////////////////
	// Output word format
	//////////////////////////////////////////////////////////////////////

	typedef logic signed [mantWidth-1:0] mant_t;
	typedef logic [expWidth-1:0] exp_t;

	// Mantissa in the upper bits, left shift count below
	typedef struct packed {
		mant_t mantissa;
		exp_t  exponent;
	} floatWord_t;

	typedef struct packed {
		floatWord_t realPart;
		floatWord_t imagPart;
	} complexFloat_t;
	typedef complexFloat_t [7:0] resultVec_t;

endpackage

//--- src/finalButterfly.sv
`timescale 1ns/1ps

module finalButterfly (
	input  logic               Clock,
	input  logic               rstN,
	input  fftPkg::stage2Vec_t stage2In,
	output fftPkg::fixedVec_t  fixedOut
);

	fftPkg::fixedVec_t fixedNext;

	//////////////////////////////////////////////////////////////////////
	// Twiddle products and final butterflies
	//////////////////////////////////////////////////////////////////////

	// Everything is kept as 256 times the true value
	always_comb begin
		fftPkg::fixed_t evenRe;
		fftPkg::fixed_t evenIm;
		fftPkg::fixed_t oddRe;
		fftPkg::fixed_t oddIm;
		fftPkg::fixed_t prodRe;
		fftPkg::fixed_t prodIm;
		for (int k = 0; k < 4; k++) begin
			evenRe = fftPkg::fixed_t'(stage2In[k].realPart) <<< fftPkg::fracBits;
			evenIm = fftPkg::fixed_t'(stage2In[k].imagPart) <<< fftPkg::fracBits;
			oddRe  = fftPkg::fixed_t'(stage2In[k + 4].realPart);
			oddIm  = fftPkg::fixed_t'(stage2In[k + 4].imagPart);

			case (k)
				0: begin
					// T(0) = 1
					prodRe = oddRe <<< fftPkg::fracBits;
					prodIm = oddIm <<< fftPkg::fracBits;
				end
				1: begin
					// (181 - j181)(a + jb)
					prodRe = fftPkg::twiddleCoef * (oddRe + oddIm);
					prodIm = fftPkg::twiddleCoef * (oddIm - oddRe);
				end
				2: begin
					// T(2) = -j, so swap and negate
					prodRe = oddIm <<< fftPkg::fracBits;
					prodIm = -(oddRe <<< fftPkg::fracBits);
				end
				default: begin
					// (-181 - j181)(a + jb)
					prodRe = fftPkg::twiddleCoef * (oddIm - oddRe);
					prodIm = -(fftPkg::twiddleCoef * (oddRe + oddIm));
				end
			endcase

			fixedNext[k].realPart     = evenRe + prodRe;
			fixedNext[k].imagPart     = evenIm + prodIm;
			fixedNext[k + 4].realPart = evenRe - prodRe;
			fixedNext[k + 4].imagPart = evenIm - prodIm;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			fixedOut <= '0;
		end else begin
			fixedOut <= fixedNext;
		end
	end

endmodule

//--- src/floatNormalizer.sv
`timescale 1ns/1ps

module floatNormalizer (
	input  logic                                Clock,
	input  logic                                rstN,
	input  logic signed [fftPkg::fixedWidth-1:0] value,
	output fftPkg::floatWord_t                  word
);

	logic [fftPkg::fixedWidth:0] extended;
	fftPkg::exp_t shiftAmt;
	fftPkg::fixed_t shifted;
	fftPkg::floatWord_t wordNext;

	// Zero shifted in below bit 0 so that -1 still finds a sign change
	assign extended = {value, 1'b0};

	//////////////////////////////////////////////////////////////////////
	// Leading-sign search
	//////////////////////////////////////////////////////////////////////

	// Scanning down means the smallest matching shift is the last one kept
	always_comb begin
		shiftAmt = '0;
		for (int k = fftPkg::fixedWidth - 1; k >= 0; k--) begin
			if (extended[fftPkg::fixedWidth - k] != extended[fftPkg::fixedWidth - 1 - k]) begin
				shiftAmt = fftPkg::exp_t'(k);
			end
		end
		shifted = value <<< shiftAmt;
	end

	always_comb begin
		if (value == '0) begin
			wordNext = '0;
		end else begin
			wordNext.mantissa = shifted[fftPkg::fixedWidth-1 -: fftPkg::mantWidth];
			wordNext.exponent = shiftAmt;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			word <= '0;
		end else begin
			word <= wordNext;
		end
	end

endmodule

//--- src/inputButterfly.sv
`timescale 1ns/1ps

module inputButterfly (
	input  logic               Clock,
	input  logic               rstN,
	input  fftPkg::sampleVec_t samples,
	output fftPkg::stage1Vec_t stage1Out
);

	fftPkg::stage1Vec_t stage1Next;

	//////////////////////////////////////////////////////////////////////
	// 2-point butterflies on bit-reversed pairs
	//////////////////////////////////////////////////////////////////////

	// Pair i uses sample bitrev(i) and bitrev(i) + 4
	always_comb begin
		fftPkg::stage1_t first;
		fftPkg::stage1_t second;
		int idx;
		for (int i = 0; i < 4; i++) begin
			idx = 2 * i[0] + i[1];
			// One guard bit through sign extension
			first  = fftPkg::stage1_t'(samples[idx]);
			second = fftPkg::stage1_t'(samples[idx + 4]);
			stage1Next[2 * i]     = first + second;
			stage1Next[2 * i + 1] = first - second;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			stage1Out <= '0;
		end else begin
			stage1Out <= stage1Next;
		end
	end

endmodule

//--- src/quarterButterfly.sv
`timescale 1ns/1ps

module quarterButterfly (
	input  logic               Clock,
	input  logic               rstN,
	input  fftPkg::stage1Vec_t stage1In,
	output fftPkg::stage2Vec_t stage2Out
);

	fftPkg::stage2Vec_t stage2Next;

	//////////////////////////////////////////////////////////////////////
	// Two 4-point DFTs
	//////////////////////////////////////////////////////////////////////

	// Half 0 is the even-index DFT, half 1 the odd-index DFT
	always_comb begin
		fftPkg::stage2Part_t w0;
		fftPkg::stage2Part_t w1;
		fftPkg::stage2Part_t w2;
		fftPkg::stage2Part_t w3;
		int base;
		for (int h = 0; h < 2; h++) begin
			base = 4 * h;
			w0 = fftPkg::stage2Part_t'(stage1In[base]);
			w1 = fftPkg::stage2Part_t'(stage1In[base + 1]);
			w2 = fftPkg::stage2Part_t'(stage1In[base + 2]);
			w3 = fftPkg::stage2Part_t'(stage1In[base + 3]);

			// Bin 0 is purely real
			stage2Next[base].realPart = w0 + w2;
			stage2Next[base].imagPart = '0;

			// Bin 1 takes -j times W3 as a negated imaginary part
			stage2Next[base + 1].realPart = w1;
			stage2Next[base + 1].imagPart = -w3;

			// Bin 2 is purely real
			stage2Next[base + 2].realPart = w0 - w2;
			stage2Next[base + 2].imagPart = '0;

			// Bin 3 takes +j times W3
			stage2Next[base + 3].realPart = w1;
			stage2Next[base + 3].imagPart = w3;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			stage2Out <= '0;
		end else begin
			stage2Out <= stage2Next;
		end
	end

endmodule

//--- verification/fftCalculator_assertions.sv
`timescale 1ns/1ps

module fftCalculatorAssertions (
	input logic               Clock,
	input logic               rstN,
	input fftPkg::resultVec_t results
);

	// Output registers clear on an edge with rstN low
	resetClears: assert property (@(posedge Clock) !rstN |=> results == '0)
		else $error("Results not zero one cycle after reset was low");

	//////////////////////////////////////////////////////////////////////
	// Output word format of each real and imaginary word
	//////////////////////////////////////////////////////////////////////

	for (genvar bin = 0; bin < 8; bin++) begin : genBin
		for (genvar part = 0; part < 2; part++) begin : genPart
			fftPkg::floatWord_t resultWord;

			assign resultWord = (part == 0) ? results[bin].realPart : results[bin].imagPart;

			// Shift count never passes the top bit
			expRange: assert property (@(posedge Clock) disable iff (!rstN)
				resultWord.exponent <= fftPkg::fixedWidth - 1)
				else $error("Bin %0d part %0d exponent out of range", bin, part);

			// Leading sign bit sits just below the top bit
			mantNormalized: assert property (@(posedge Clock) disable iff (!rstN)
				resultWord.mantissa != '0 |->
				resultWord.mantissa[fftPkg::mantWidth-1] !=
				resultWord.mantissa[fftPkg::mantWidth-2])
				else $error("Bin %0d part %0d mantissa not normalized", bin, part);

			zeroWord: assert property (@(posedge Clock) disable iff (!rstN)
				resultWord.mantissa == '0 |-> resultWord.exponent == '0)
				else $error("Bin %0d part %0d zero mantissa with nonzero exponent", bin, part);
		end
	end

endmodule

bind fftCalculator fftCalculatorAssertions resultChecks (
	.Clock(Clock),
	.rstN(rstN),
	.results(results)
);

//--- verification/fftPatterns.txt
// Each set is two lines. First the samples x7..x0 as one 64-bit word, then the
// result words real and imag of bins 0 to 3, and on the next line those of bins 4 to 7.
// A result word is the 15-bit mantissa followed by the 5-bit exponent.
// DC inputs 10, -3, -128 and 127
0a0a0a0a0a0a0a0a 50004 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
fdfdfdfdfdfdfdfd a0006 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
8080808080808080 80001 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
7f7f7f7f7f7f7f7f 7f001 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
// Impulse on sample 0, values 100 and -128
0000000000000064 64004 00000 64004 00000 64004 00000 64004 00000
64004 00000 64004 00000 64004 00000 64004 00000
0000000000000080 80004 00000 80004 00000 80004 00000 80004 00000
80004 00000 80004 00000 80004 00000 80004 00000
// Alternating signs, +5 -5 and -64 +64
fb05fb05fb05fb05 00000 00000 00000 00000 00000 00000 00000 00000
50005 00000 00000 00000 00000 00000 00000 00000
40c040c040c040c0 00000 00000 00000 00000 00000 00000 00000 00000
80002 00000 00000 00000 00000 00000 00000 00000
// Single odd samples through the 181/256 twiddles
0000000000000100 4000a 00000 5a80b a580b 00000 8000b a580b a580b
8000b 00000 a580b 5a80b 00000 4000a 5a80b 5a80b
000000000000ff00 8000b 00000 a580b 5a80b 00000 4000a 5a80b 5a80b
4000a 00000 5a80b a580b 00000 8000b a580b a580b
0000000000007f00 7f004 00000 59ca4 a6344 00000 81004 a6344 a6344
81004 00000 a6344 59ca4 00000 7f004 59ca4 59ca4
0000000000fe0000 8000a 00000 00000 40009 40009 00000 00000 8000a
8000a 00000 00000 40009 40009 00000 00000 8000a
0000000025000000 4a005 00000 975c6 975c6 00000 4a005 68a46 975c6
b6005 00000 68a46 68a46 00000 b6005 975c6 68a46
// Ramp 0 to 7, a mixed set with negative values, all zero
0706050403020100 70006 00000 80009 4d407 80009 40008 80009 6a00a
80009 00000 80009 9600a 80009 80009 80009 b2c07
0406ff02fb0003f8 4000a 00000 9880b 4c487 a0007 a0009 b33c6 b1209
8000b 00000 b33c6 4ee09 a0007 60009 9880b b3b87
0000000000000000 00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000

//--- verification/tbFftCalculator.sv
`timescale 1ns/1ps

module tbFftCalculator;

	localparam int patternCount = 16;
	// One sample word and sixteen result words per set
	localparam int wordsPerRecord = 17;
	// Sets in flight between the input and the results
	localparam int pipeDepth = 4;
	localparam int cycleLimit = patternCount + 20;

	logic Clock;
	logic rstN;
	fftPkg::sampleVec_t samples;
	fftPkg::resultVec_t results;

	logic [63:0] patternMem [0:patternCount*wordsPerRecord-1];

	// Record index of each set in flight or -1 for an idle slot
	int expectQueue [$];

	int cycleCount = 0;
	int checkCount = 0;
	int valueErrors = 0;
	int resetErrors = 0;
	int fileErrors = 0;

	fftCalculator dut (
		.Clock(Clock),
		.rstN(rstN),
		.samples(samples),
		.results(results)
	);

	always #4 Clock = ~Clock;

	//////////////////////////////////////////////////////////////////////
	// Run limit
	//////////////////////////////////////////////////////////////////////

	always @(posedge Clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Expected values and comparison
	//////////////////////////////////////////////////////////////////////

	// Idle slots expect all-zero words
	function automatic logic [19:0] expectedWord(input int recordIdx, input int bin,
		input int part);
		int addr;
		if (recordIdx < 0) begin
			return '0;
		end
		addr = recordIdx * wordsPerRecord + 1 + 2 * bin + part;
		return patternMem[addr][19:0];
	endfunction

	task automatic compareResults(input int recordIdx, input bit duringReset);
		logic [19:0] expWord;
		logic [19:0] gotWord;
		string setName;
		string partName;
		if (recordIdx < 0) begin
			setName = "idle slot";
		end else begin
			setName = $sformatf("set %0d", recordIdx);
		end
		for (int bin = 0; bin < 8; bin++) begin
			for (int part = 0; part < 2; part++) begin
				expWord = expectedWord(recordIdx, bin, part);
				if (part == 0) begin
					gotWord = results[bin].realPart;
					partName = "real";
				end else begin
					gotWord = results[bin].imagPart;
					partName = "imag";
				end
				checkCount++;
				assert (gotWord === expWord) else begin
					if (duringReset) begin
						resetErrors++;
					end else begin
						valueErrors++;
					end
					$display("Error at %0d ns: %s bin %0d %s expected %h got %h",
						$time, setName, bin, partName, expWord, gotWord);
				end
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		Clock = 1'b0;
		rstN = 1'b0;
		// Nonzero input while in reset must still leave the registers clear
		samples = {8{8'h5a}};
		$readmemh("verification/fftPatterns.txt", patternMem);

		assert (!$isunknown(patternMem[0])) else begin
			fileErrors++;
			$display("The pattern file verification/fftPatterns.txt could not be read");
		end

		// Slots ahead of the first set come out of reset as zeros
		for (int i = 0; i < pipeDepth; i++) begin
			expectQueue.push_back(-1);
		end

		repeat (3) begin
			@(negedge Clock);
			compareResults(-1, 1'b1);
		end
		rstN = 1'b1;
		samples = '0;

		// One set per cycle, back to back, then drain the pipeline
		for (int n = 0; n < patternCount + pipeDepth; n++) begin
			@(negedge Clock);
			compareResults(expectQueue.pop_front(), 1'b0);
			if (n < patternCount) begin
				samples = patternMem[n * wordsPerRecord];
				expectQueue.push_back(n);
			end else begin
				samples = '0;
				expectQueue.push_back(-1);
			end
		end

		$display("Checks: %0d, value errors: %0d, reset errors: %0d, file errors: %0d",
			checkCount, valueErrors, resetErrors, fileErrors);
		if (valueErrors + resetErrors + fileErrors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
